// ==== all.f ====
+incdir+source
source/dnc_pkg.sv
source/ntm_scalar_logistic_function.sv
source/ntm_vector_logistic_function.sv
source/dnc_erase_vector.sv
verif/dnc_erase_vector_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the erase-vector testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  -f all.f --top-module dnc_erase_vector_tb -o dnc_erase_vector_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit 1
fi

output=$(./obj_dir/dnc_erase_vector_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
  exit 0
else
  exit 1
fi

// ==== source/dnc_erase_vector.sv ====
`timescale 1ns/1ps
`default_nettype none

module dnc_erase_vector
  import dnc_pkg::*;
(
  // Global
  input  logic   clk,
  input  logic   rst,

  // Control
  input  logic   start,
  output logic   ready,
  input  logic   e_in_enable,   // k in 0 to W-1
  output logic   e_out_enable,  // k in 0 to W-1

  // Data
  input  size_t  size_w_in,
  input  fixed_t e_in,
  output fixed_t e_out
);

  //////////////////////////////////////////////////
  // Erase vector of the write head
  //////////////////////////////////////////////////

  // e(t;k) = sigmoid(e^(t;k))

  // Vector logistic control
  logic   start_vector_logistic;
  logic   ready_vector_logistic;
  logic   data_in_enable_vector_logistic;
  logic   data_out_enable_vector_logistic;

  // Vector logistic data
  size_t  size_in_vector_logistic;
  fixed_t data_in_vector_logistic;
  fixed_t data_out_vector_logistic;

  assign start_vector_logistic          = start;
  assign ready                          = ready_vector_logistic;
  assign data_in_enable_vector_logistic = e_in_enable;
  assign e_out_enable                   = data_out_enable_vector_logistic;

  assign size_in_vector_logistic = size_w_in;
  assign data_in_vector_logistic = e_in;
  assign e_out                   = data_out_vector_logistic;

  ntm_vector_logistic_function vector_logistic_function (
    .clk            (clk),
    .rst            (rst),
    .start          (start_vector_logistic),
    .ready          (ready_vector_logistic),
    .data_in_enable (data_in_enable_vector_logistic),
    .data_out_enable(data_out_enable_vector_logistic),
    .size_in        (size_in_vector_logistic),
    .data_in        (data_in_vector_logistic),
    .data_out       (data_out_vector_logistic)
  );

endmodule

`default_nettype wire

// ==== source/dnc_macros.svh ====
`ifndef DNC_MACROS_SVH
`define DNC_MACROS_SVH

// Fixed-point element width
`define DNC_DATA_SIZE 16

// Fraction bits of an element, Q8.8
`define DNC_FRAC_SIZE 8

// Width of the vector length and element index
`define DNC_SIZE_SIZE 16

// PLAN breakpoints in Q8.8
// 1.0
`define DNC_PLAN_X1 256
// 2.375
`define DNC_PLAN_X2 608
// 5.0
`define DNC_PLAN_X3 1280

`endif

// ==== source/dnc_pkg.sv ====
`default_nettype none

`include "dnc_macros.svh"

package dnc_pkg;

  //////////////////////////////////////////////////
  // Data types
  //////////////////////////////////////////////////

  // Signed Q8.8 element
  typedef logic signed [`DNC_DATA_SIZE-1:0] fixed_t;

  // Vector length or element index
  typedef logic [`DNC_SIZE_SIZE-1:0] size_t;

  //////////////////////////////////////////////////
  // PLAN segments
  //////////////////////////////////////////////////

  // Ordered by growing magnitude
  typedef enum logic [1:0] {
    SEG_LINEAR_QUARTER      = 2'd0,  // m < 1.0
    SEG_LINEAR_EIGHTH       = 2'd1,  // 1.0 <= m < 2.375
    SEG_LINEAR_THIRTYSECOND = 2'd2,  // 2.375 <= m < 5.0
    SEG_SATURATED           = 2'd3   // m >= 5.0
  } plan_segment_e;

  //////////////////////////////////////////////////
  // Pipeline stage
  //////////////////////////////////////////////////

  // One element between scalar stage 1 and stage 2
  typedef struct packed {
    logic          valid;
    logic          negative;
    fixed_t        magnitude;
    plan_segment_e segment;
  } logistic_stage_t;

endpackage

`default_nettype wire

// ==== source/ntm_scalar_logistic_function.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dnc_macros.svh"

module ntm_scalar_logistic_function
  import dnc_pkg::*;
(
  // Global
  input  logic   clk,
  input  logic   rst,

  // Control
  input  logic   data_in_enable,
  output logic   data_out_enable,

  // Data
  input  fixed_t data_in,
  output fixed_t data_out
);

  //////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////

  // Extremes of the signed element range
  localparam fixed_t FIXED_MAX = {1'b0, {(`DNC_DATA_SIZE-1){1'b1}}};
  localparam fixed_t FIXED_MIN = {1'b1, {(`DNC_DATA_SIZE-1){1'b0}}};

  // 1.0 in Q8.8
  localparam fixed_t ONE = fixed_t'(1) <<< `DNC_FRAC_SIZE;

  // Segment offsets
  localparam fixed_t OFFSET_QUARTER      = fixed_t'(128);  // 0.5
  localparam fixed_t OFFSET_EIGHTH       = fixed_t'(160);  // 0.625
  localparam fixed_t OFFSET_THIRTYSECOND = fixed_t'(216);  // 0.84375

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  logistic_stage_t stage_d;
  logistic_stage_t stage_q;

  fixed_t slope_term;
  fixed_t offset;
  fixed_t positive_y;
  fixed_t result;

  //////////////////////////////////////////////////
  // Stage 1 sign, magnitude and segment
  //////////////////////////////////////////////////

  always_comb begin
    stage_d.valid    = data_in_enable;
    stage_d.negative = data_in[`DNC_DATA_SIZE-1];

    // Magnitude, most negative value clips to the most positive one
    if (data_in == FIXED_MIN) begin
      stage_d.magnitude = FIXED_MAX;
    end else if (stage_d.negative) begin
      stage_d.magnitude = -data_in;
    end else begin
      stage_d.magnitude = data_in;
    end

    // Breakpoint compare
    if (stage_d.magnitude >= fixed_t'(`DNC_PLAN_X3)) begin
      stage_d.segment = SEG_SATURATED;
    end else if (stage_d.magnitude >= fixed_t'(`DNC_PLAN_X2)) begin
      stage_d.segment = SEG_LINEAR_THIRTYSECOND;
    end else if (stage_d.magnitude >= fixed_t'(`DNC_PLAN_X1)) begin
      stage_d.segment = SEG_LINEAR_EIGHTH;
    end else begin
      stage_d.segment = SEG_LINEAR_QUARTER;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stage_q <= '0;
    end else begin
      stage_q <= stage_d;
    end
  end

  //////////////////////////////////////////////////
  // Stage 2 shift, offset and mirror
  //////////////////////////////////////////////////

  always_comb begin
    // Magnitude is never negative, shifts truncate
    unique case (stage_q.segment)
      SEG_LINEAR_QUARTER: begin
        slope_term = stage_q.magnitude >>> 2;
        offset     = OFFSET_QUARTER;
      end
      SEG_LINEAR_EIGHTH: begin
        slope_term = stage_q.magnitude >>> 3;
        offset     = OFFSET_EIGHTH;
      end
      SEG_LINEAR_THIRTYSECOND: begin
        slope_term = stage_q.magnitude >>> 5;
        offset     = OFFSET_THIRTYSECOND;
      end
      SEG_SATURATED: begin
        slope_term = '0;
        offset     = ONE;
      end
    endcase

    positive_y = slope_term + offset;

    // sigmoid(-x) = 1 - sigmoid(x)
    result = stage_q.negative ? ONE - positive_y : positive_y;
  end

  // Output register, value held between strobes
  always_ff @(posedge clk) begin
    if (rst) begin
      data_out_enable <= 1'b0;
      data_out        <= '0;
    end else begin
      data_out_enable <= stage_q.valid;
      if (stage_q.valid) begin
        data_out <= result;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/ntm_vector_logistic_function.sv ====
`timescale 1ns/1ps
`default_nettype none

module ntm_vector_logistic_function
  import dnc_pkg::*;
(
  // Global
  input  logic   clk,
  input  logic   rst,

  // Control
  input  logic   start,
  output logic   ready,
  input  logic   data_in_enable,
  output logic   data_out_enable,

  // Data
  input  size_t  size_in,
  input  fixed_t data_in,
  output fixed_t data_out
);

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  // Latched vector length
  size_t size_q;

  // Elements taken in, elements issued to the output stage
  size_t in_count;
  size_t out_count;

  logic busy;
  logic accept;
  logic accept_d1;
  logic last_issue;

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  // Only the first W strobes after start enter the pipeline
  assign accept = busy && data_in_enable && (in_count != size_q);

  // Last element moves into the output register on this edge
  assign last_issue = accept_d1 && (out_count == size_q - size_t'(1));

  assign ready = !busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      size_q    <= '0;
      in_count  <= '0;
      out_count <= '0;
      accept_d1 <= 1'b0;
    end else begin
      // Mirrors stage 1 valid of the scalar unit
      accept_d1 <= accept;

      if (start && !busy) begin
        size_q    <= size_in;
        in_count  <= '0;
        out_count <= '0;
        // Empty vector stays idle
        busy      <= (size_in != '0);
      end else begin
        if (accept) begin
          in_count <= in_count + size_t'(1);
        end
        if (accept_d1) begin
          out_count <= out_count + size_t'(1);
        end
        // Ready rises with the last output strobe
        if (last_issue) begin
          busy <= 1'b0;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Scalar unit
  //////////////////////////////////////////////////

  ntm_scalar_logistic_function scalar_logistic_function (
    // Global
    .clk            (clk),
    .rst            (rst),

    // Control
    .data_in_enable (accept),
    .data_out_enable(data_out_enable),

    // Data
    .data_in        (data_in),
    .data_out       (data_out)
  );

endmodule

`default_nettype wire

// ==== verif/dnc_erase_vector_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dnc_macros.svh"

module dnc_erase_vector_tb
  import dnc_pkg::*;
;

  //////////////////////////////////////////////////
  // Run limits
  //////////////////////////////////////////////////

  // Budget for all tests, about twice their worst-case length
  localparam int TEST_CYCLES    = 200;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic   clk;
  logic   rst;
  logic   start;
  logic   ready;
  logic   e_in_enable;
  logic   e_out_enable;
  size_t  size_w_in;
  fixed_t e_in;
  fixed_t e_out;

  // Bookkeeping
  int     cycle;
  int     errors;
  int     checks;
  int     tests_run;
  int     outputs_seen;
  int     vector_len;
  fixed_t exp_q[$];
  int     exp_cycle_q[$];
  fixed_t exp_value;
  int     exp_cycle;

  dnc_erase_vector dut (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .ready       (ready),
    .e_in_enable (e_in_enable),
    .e_out_enable(e_out_enable),
    .size_w_in   (size_w_in),
    .e_in        (e_in),
    .e_out       (e_out)
  );

  // 8 ns clock
  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout, run passed %0d cycles", TIMEOUT_CYCLES);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Reference model and compares
  //////////////////////////////////////////////////

  // PLAN sigmoid on the truncated magnitude
  function automatic fixed_t plan_sigmoid(input fixed_t x);
    int m;
    int y;
    m = int'(x);
    if (m < 0) m = -m;
    // -32768 clips
    if (m > 32767) m = 32767;
    if (m >= `DNC_PLAN_X3) y = 256;
    else if (m >= `DNC_PLAN_X2) y = (m >>> 5) + 216;
    else if (m >= `DNC_PLAN_X1) y = (m >>> 3) + 160;
    else y = (m >>> 2) + 128;
    if (x < 0) y = 256 - y;
    return fixed_t'(y);
  endfunction

  task automatic check_fixed(input string name, input fixed_t got, input fixed_t exp);
    checks = checks + 1;
    if (got !== exp) begin
      $display("** Error: %s = 0x%04h, expected 0x%04h", name, got, exp);
      errors = errors + 1;
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    checks = checks + 1;
    if (got !== exp) begin
      $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
      errors = errors + 1;
    end
  endtask

  task automatic check_size(input string name, input size_t got, input size_t exp);
    checks = checks + 1;
    if (got !== exp) begin
      $display("** Error: %s = 0x%04h, expected 0x%04h", name, got, exp);
      errors = errors + 1;
    end
  endtask

  //////////////////////////////////////////////////
  // Output monitor
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!rst && e_out_enable === 1'b1) begin
      // Every strobe counts, expected or not
      outputs_seen = outputs_seen + 1;
      if (exp_q.size() == 0) begin
        $display("Output strobe at cycle %0d with no element pending", cycle);
        errors = errors + 1;
      end else begin
        exp_value = exp_q.pop_front();
        exp_cycle = exp_cycle_q.pop_front();
        check_fixed("e_out", e_out, exp_value);
        if (cycle != exp_cycle) begin
          $display("Output due at cycle %0d came at cycle %0d", exp_cycle, cycle);
          errors = errors + 1;
        end
        // High only with the last output of the vector
        check_level("ready", ready, outputs_seen == vector_len);
      end
    end
  end

  //////////////////////////////////////////////////
  // Drivers, called on the falling edge
  //////////////////////////////////////////////////

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic start_vector(input size_t w);
    start        = 1'b1;
    size_w_in    = w;
    vector_len   = int'(w);
    outputs_seen = 0;
    @(negedge clk);
    start = 1'b0;
    check_level("ready", ready, w == '0);
  endtask

  // One strobe, expected result queued if the DUT takes it
  task automatic drive_element(input fixed_t x, input logic accepted);
    e_in_enable = 1'b1;
    e_in        = x;
    if (accepted) begin
      exp_q.push_back(plan_sigmoid(x));
      exp_cycle_q.push_back(cycle + 2);
    end
    @(negedge clk);
    e_in_enable = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(posedge clk);
    @(negedge clk);
    check_level("ready", ready, 1'b1);
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests_run = tests_run + 1;
    $display("%s finished with %0d errors", name, errors - errors_before);
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_reset_state();
    int errors_before;
    errors_before = errors;
    check_fixed("e_out", e_out, '0);
    // Stray strobes while idle
    repeat (6) begin
      check_level("ready", ready, 1'b1);
      check_level("e_out_enable", e_out_enable, 1'b0);
      drive_element(fixed_t'($urandom()), 1'b0);
    end
    idle_cycles(3);
    check_size("outputs", size_t'(outputs_seen), '0);
    end_test("reset_state", errors_before);
  endtask

  task automatic test_segment_boundaries();
    int     errors_before;
    fixed_t values[11];
    errors_before = errors;
    values = '{16'sd0, 16'sd256, -16'sd256, 16'sd607, 16'sd609, -16'sd607, -16'sd609,
               16'sd1280, -16'sd1280, 16'sh7fff, -16'sh8000};
    start_vector(size_t'(11));
    foreach (values[i]) begin
      drive_element(values[i], 1'b1);
      idle_cycles(1);
    end
    wait_drain();
    check_size("outputs", size_t'(outputs_seen), size_t'(11));
    end_test("segment_boundaries", errors_before);
  endtask

  task automatic test_back_to_back();
    int errors_before;
    errors_before = errors;
    start_vector(size_t'(16));
    repeat (16) drive_element(fixed_t'($urandom()), 1'b1);
    wait_drain();
    check_size("outputs", size_t'(outputs_seen), size_t'(16));
    end_test("back_to_back", errors_before);
  endtask

  task automatic test_gapped_input();
    int errors_before;
    errors_before = errors;
    start_vector(size_t'(5));
    for (int i = 0; i < 5; i++) begin
      drive_element(fixed_t'($urandom()), 1'b1);
      idle_cycles($urandom() % 3);
      // Start while busy has no effect
      if (i == 1) begin
        start     = 1'b1;
        size_w_in = size_t'(7);
        @(negedge clk);
        start = 1'b0;
        check_level("ready", ready, 1'b0);
      end
    end
    repeat (3) drive_element(fixed_t'($urandom()), 1'b0);
    wait_drain();
    idle_cycles(4);
    check_size("outputs", size_t'(outputs_seen), size_t'(5));
    end_test("gapped_input", errors_before);
  endtask

  task automatic test_restart_empty();
    int errors_before;
    errors_before = errors;
    start_vector('0);
    drive_element(fixed_t'($urandom()), 1'b0);
    idle_cycles(3);
    check_level("ready", ready, 1'b1);
    check_size("outputs", size_t'(outputs_seen), '0);
    // Counters cleared for the next vector
    start_vector(size_t'(4));
    repeat (4) drive_element(fixed_t'($urandom()), 1'b1);
    wait_drain();
    check_size("outputs", size_t'(outputs_seen), size_t'(4));
    end_test("restart_empty", errors_before);
  endtask

  initial begin
    void'($urandom(32'h2517_0f78));
    cycle        = 0;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    outputs_seen = 0;
    vector_len   = 0;
    rst          = 1'b1;
    start        = 1'b0;
    e_in_enable  = 1'b0;
    size_w_in    = '0;
    e_in         = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_reset_state();
    test_segment_boundaries();
    test_back_to_back();
    test_gapped_input();
    test_restart_empty();

    $display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
